// File: Makefile
# Verilator build and run for the sound board glue logic

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_dkong_sound
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := TESTBENCH FAILED

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "Simulator exited with status $$status"; exit 1; fi
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Failure reported in $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
+incdir+src
src/snd_bus_pkg.sv
src/snd_host_pkg.sv
src/snd_addr_latch.sv
src/snd_cmd_sync.sv
src/snd_cpu_port_io.sv
src/dkong_sound.sv
tests/tb_dkong_sound.sv

// File: src/dkong_sound.sv
//==================================================
// Top of the sound board glue logic
// Sits between the sound microcontroller, the main CPU
// command lines and an external 4 KB program/data ROM
//==================================================
`timescale 1ns/100ps
`include "snd_config.svh"

module dkong_sound
	import snd_bus_pkg::*;
	import snd_host_pkg::*;
(
	input  logic                 I_CLK,
	input  logic                 rst_n,
	// Microcontroller bus
	input  logic [`SND_DB_W-1:0] db_in,
	input  bus_strobe_t          strobe,
	input  logic [`SND_DB_W-1:0] port1,
	input  port2_t               port2,
	output logic [`SND_DB_W-1:0] db_out,
	output snd_pins_t            pins,
	output logic [`SND_DB_W-1:0] port2_out,
	output logic                 cpu_rst_n,
	// Main CPU command
	input  snd_cmd_t             cmd,
	// External ROM
	output rom_addr_t            rom_addr,
	input  logic [`SND_DB_W-1:0] rom_data,
	// DAC sample
	output logic [`SND_DB_W-1:0] dac
);

	// Synchronized sound data nibble
	logic [`SND_NIB_W-1:0] cmd_dat;

	//==================================================
	// Stage 1 address latch
	//==================================================
	snd_addr_latch u_addr_latch (
		.I_CLK    (I_CLK),
		.rst_n    (rst_n),
		.db_in    (db_in),
		.strobe   (strobe),
		.port2    (port2),
		.rom_addr (rom_addr)
	);

	//==================================================
	// Command synchronizer
	//==================================================
	snd_cmd_sync u_cmd_sync (
		.I_CLK     (I_CLK),
		.rst_n     (rst_n),
		.cmd       (cmd),
		.pins      (pins),
		.cmd_dat   (cmd_dat),
		.cpu_rst_n (cpu_rst_n)
	);

	//==================================================
	// Stage 2 data return and DAC
	//==================================================
	snd_cpu_port_io u_port_io (
		.I_CLK    (I_CLK),
		.rst_n    (rst_n),
		.strobe   (strobe),
		.port2    (port2),
		.port1    (port1),
		.rom_data (rom_data),
		.cmd_dat  (cmd_dat),
		.db_out   (db_out),
		.dac      (dac)
	);

	// Port 2 input side only uses bit 5
	// Other bits read back as zero
	always_comb begin
		port2_out    = '0;
		port2_out[5] = pins.p2_5;
	end

endmodule

// File: src/snd_addr_latch.sv
//==================================================
// Pipeline stage 1 of the sound board
// Catches the low address byte off the multiplexed bus
// on ALE falling and builds the 12-bit ROM address
//==================================================
`timescale 1ns/100ps
`include "snd_config.svh"

module snd_addr_latch
	import snd_bus_pkg::*;
(
	input  logic                 I_CLK,
	input  logic                 rst_n,
	input  logic [`SND_DB_W-1:0] db_in,
	input  bus_strobe_t          strobe,
	input  port2_t               port2,
	output rom_addr_t            rom_addr
);

	//==================================================
	// ALE edge detect
	//==================================================
	// Previous ALE sample
	logic ale_q;
	// Falling edge seen in this cycle
	logic ale_fall;

	// Latched low address byte
	logic [`SND_DB_W-1:0] offset_q;

	always_ff @(posedge I_CLK or negedge rst_n) begin
		if (!rst_n) begin
			ale_q <= 1'b0;
		end else begin
			ale_q <= strobe.ale;
		end
	end

	// High last cycle and low now
	assign ale_fall = ale_q & ~strobe.ale;

	//==================================================
	// Offset register
	//==================================================
	// Only loads on the falling edge
	// db_in may move freely while ALE stays low
	always_ff @(posedge I_CLK or negedge rst_n) begin
		if (!rst_n) begin
			offset_q <= '0;
		end else if (ale_fall) begin
			offset_q <= db_in;
		end
	end

	//==================================================
	// Address assembly
	//==================================================
	// Page and half follow port 2 without a register
	// Data half is selected when the command latch is not
	always_comb begin
		rom_addr.data_half = ~port2.sel_cmd;
		rom_addr.page      = port2.page;
		rom_addr.offset    = offset_q;
	end

endmodule

// File: src/snd_bus_pkg.sv
//==================================================
// Types for the sound microcontroller bus side
// Strobes, port 2 layout and the external ROM address
//==================================================
`include "snd_config.svh"

package snd_bus_pkg;

	//==================================================
	// Bus strobes
	//==================================================
	// ALE is active high, the read strobes are active low
	typedef struct packed {
		logic ale;
		logic rd_n;
		logic psen_n;
	} bus_strobe_t;

	//==================================================
	// Port 2 as seen by the glue logic
	//==================================================
	// Bit 6 high reads the host command latch
	// Bit 6 low reads the data ROM
	typedef struct packed {
		logic                               spare_hi;
		logic                               sel_cmd;
		logic [`SND_DB_W-`SND_PAGE_W-3:0]   spare_lo;
		logic [`SND_PAGE_W-1:0]             page;
	} port2_t;

	//==================================================
	// ROM address
	//==================================================
	// data_half set selects the upper 2 KB
	typedef struct packed {
		logic                   data_half;
		logic [`SND_PAGE_W-1:0] page;
		logic [`SND_DB_W-1:0]   offset;
	} rom_addr_t;

endpackage

// File: src/snd_cmd_sync.sv
//==================================================
// Side stage that brings the main CPU command into the
// sound clock domain and drives the core control pins
// Also holds the core in reset one clock past the board
//==================================================
`timescale 1ns/100ps
`include "snd_config.svh"

module snd_cmd_sync
	import snd_host_pkg::*;
(
	input  logic                  I_CLK,
	input  logic                  rst_n,
	input  snd_cmd_t              cmd,
	output snd_pins_t             pins,
	output logic [`SND_NIB_W-1:0] cmd_dat,
	output logic                  cpu_rst_n
);

	//==================================================
	// Synchronizer chain
	//==================================================
	// Stage 0 takes the raw host value
	snd_cmd_t sync_q [`SND_SYNC_STAGES];

	// Oldest stage drives everything downstream
	snd_cmd_t cmd_s;

	// Core reset register
	logic core_rst_q;

	always_ff @(posedge I_CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `SND_SYNC_STAGES; i++) begin
				sync_q[i] <= '0;
			end
		end else begin
			sync_q[0] <= cmd;
			// Shift toward the last stage
			for (int i = 1; i < `SND_SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	assign cmd_s = sync_q[`SND_SYNC_STAGES-1];

	//==================================================
	// Pin drive
	//==================================================
	// Host control lines are active low at the core
	// A cleared chain leaves all four pins high
	always_comb begin
		pins.t0    = ~cmd_s.ctl[3];
		pins.t1    = ~cmd_s.ctl[2];
		pins.p2_5  = ~cmd_s.ctl[1];
		pins.int_n = ~cmd_s.ctl[0];
	end

	// Sound data goes to the command read path as is
	assign cmd_dat = cmd_s.dat;

	//==================================================
	// Core reset
	//==================================================
	// Asserted with the board reset
	// Released on the first edge after rst_n rises
	always_ff @(posedge I_CLK or negedge rst_n) begin
		if (!rst_n) begin
			core_rst_q <= 1'b0;
		end else begin
			core_rst_q <= 1'b1;
		end
	end

	assign cpu_rst_n = core_rst_q;

endmodule

// File: src/snd_config.svh
//==================================================
// Build constants for the sound board glue logic
// Include in any file that needs bus or nibble widths
//==================================================
`ifndef SND_CONFIG_SVH
`define SND_CONFIG_SVH

// Microcontroller data bus and port width
`define SND_DB_W 8

// External ROM address width
// Top bit picks the data half, the rest is page plus offset
`define SND_ROM_AW 12

// Address page taken from port 2
`define SND_PAGE_W (`SND_ROM_AW - `SND_DB_W - 1)

// Main CPU command and control nibble width
`define SND_NIB_W 4

// Flop depth of the command synchronizer
// 3 also works for a slower host clock domain
`define SND_SYNC_STAGES 2

`endif

// File: src/snd_cpu_port_io.sv
//==================================================
// Pipeline stage 2 of the sound board
// Merges program fetch, data ROM and command reads into
// the returned data bus, and samples port 1 for the DAC
//==================================================
`timescale 1ns/100ps
`include "snd_config.svh"

module snd_cpu_port_io
	import snd_bus_pkg::*;
(
	input  logic                  I_CLK,
	input  logic                  rst_n,
	input  bus_strobe_t           strobe,
	input  port2_t                port2,
	input  logic [`SND_DB_W-1:0]  port1,
	input  logic [`SND_DB_W-1:0]  rom_data,
	input  logic [`SND_NIB_W-1:0] cmd_dat,
	output logic [`SND_DB_W-1:0]  db_out,
	output logic [`SND_DB_W-1:0]  dac
);

	//==================================================
	// Read source decode
	//==================================================
	// Command latch select lags the strobe by a cycle
	logic cmd_sel_q;

	// Data ROM read is taken straight from the strobe
	logic rom_sel;

	// Per source contributions, zero when not selected
	logic [`SND_DB_W-1:0] prog_d;
	logic [`SND_DB_W-1:0] rom_d;
	logic [`SND_DB_W-1:0] cmd_d;

	// Merged bus value ahead of the output register
	logic [`SND_DB_W-1:0] merged;

	// Output registers
	logic [`SND_DB_W-1:0] db_q;
	logic [`SND_DB_W-1:0] dac_q;

	always_ff @(posedge I_CLK or negedge rst_n) begin
		if (!rst_n) begin
			cmd_sel_q <= 1'b0;
		end else begin
			cmd_sel_q <= port2.sel_cmd & ~strobe.rd_n;
		end
	end

	assign rom_sel = ~port2.sel_cmd & ~strobe.rd_n;

	//==================================================
	// Source gating and merge
	//==================================================
	always_comb begin
		// Program fetch
		prog_d = strobe.psen_n ? '0 : rom_data;
		// Data ROM read
		rom_d  = rom_sel ? rom_data : '0;
		// Command read puts the inverted nibble in the low half
		cmd_d  = '0;
		if (cmd_sel_q) begin
			cmd_d[`SND_NIB_W-1:0] = ~cmd_dat;
		end
		// Wired OR of every source like the board bus
		merged = prog_d | rom_d | cmd_d;
	end

	//==================================================
	// Output registers
	//==================================================
	// Data bus is refreshed every clock
	always_ff @(posedge I_CLK or negedge rst_n) begin
		if (!rst_n) begin
			db_q <= '0;
		end else begin
			db_q <= merged;
		end
	end

	// DAC sample is port 1 delayed by one clock
	always_ff @(posedge I_CLK or negedge rst_n) begin
		if (!rst_n) begin
			dac_q <= '0;
		end else begin
			dac_q <= port1;
		end
	end

	assign db_out = db_q;
	assign dac    = dac_q;

endmodule

// File: src/snd_host_pkg.sv
//==================================================
// Types for the main CPU side of the sound board
// Posted command and the pins it drives on the core
//==================================================
`include "snd_config.svh"

package snd_host_pkg;

	//==================================================
	// Command posted by the main CPU
	//==================================================
	// dat is read back through the command latch
	// ctl bits drive the test and interrupt pins
	typedef struct packed {
		logic [`SND_NIB_W-1:0] dat;
		logic [`SND_NIB_W-1:0] ctl;
	} snd_cmd_t;

	//==================================================
	// Microcontroller control pins
	//==================================================
	// All four are inverted copies of ctl
	// t0    from ctl bit 3
	// t1    from ctl bit 2
	// p2_5  from ctl bit 1
	// int_n from ctl bit 0
	typedef struct packed {
		logic t0;
		logic t1;
		logic int_n;
		logic p2_5;
	} snd_pins_t;

endpackage

// File: tests/tb_dkong_sound.sv
//==================================================
// Directed testbench for the sound board glue logic
// Models the external ROM as a combinational table and
// checks address latch, data return, pins and DAC
//==================================================
`timescale 1ns/100ps
`include "snd_config.svh"

module tb_dkong_sound
	import snd_bus_pkg::*;
	import snd_host_pkg::*;
();

	//==================================================
	// DUT signals
	//==================================================
	logic                 I_CLK;
	logic                 rst_n;
	logic [`SND_DB_W-1:0] db_in;
	bus_strobe_t          strobe;
	logic [`SND_DB_W-1:0] port1;
	port2_t               port2;
	logic [`SND_DB_W-1:0] db_out;
	snd_pins_t            pins;
	logic [`SND_DB_W-1:0] port2_out;
	logic                 cpu_rst_n;
	snd_cmd_t             cmd;
	rom_addr_t            rom_addr;
	logic [`SND_DB_W-1:0] rom_data;
	logic [`SND_DB_W-1:0] dac;

	// Random source and score keeping
	logic [31:0] lfsr;
	int          err_cnt;
	int          chk_cnt;
	bit          timed_out;

	// Offset held in the DUT latch after the last ALE pulse
	logic [`SND_DB_W-1:0] last_off;

	dkong_sound UUT (
		.I_CLK     (I_CLK),
		.rst_n     (rst_n),
		.db_in     (db_in),
		.strobe    (strobe),
		.port1     (port1),
		.port2     (port2),
		.db_out    (db_out),
		.pins      (pins),
		.port2_out (port2_out),
		.cpu_rst_n (cpu_rst_n),
		.cmd       (cmd),
		.rom_addr  (rom_addr),
		.rom_data  (rom_data),
		.dac       (dac)
	);

	// 4 ns clock
	initial begin
		I_CLK = 1'b0;
		forever #2 I_CLK = ~I_CLK;
	end

	//==================================================
	// Models and helpers
	//==================================================
	// ROM byte is the offset XOR the top four address bits in both nibbles
	function automatic logic [`SND_DB_W-1:0] rom_model(input rom_addr_t a);
		logic [3:0] hi;
		hi = {a.data_half, a.page};
		return a.offset ^ {hi, hi};
	endfunction

	assign rom_data = rom_model(rom_addr);

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Address the board should present for a driven offset and port 2
	function automatic rom_addr_t expect_addr(input logic [`SND_DB_W-1:0] off,
		input port2_t p2);
		rom_addr_t a;
		a.data_half = ~p2.sel_cmd;
		a.page      = p2.page;
		a.offset    = off;
		return a;
	endfunction

	// Core pins are the inverted host control bits
	function automatic snd_pins_t pins_of(input snd_cmd_t c);
		snd_pins_t p;
		p.t0    = ~c.ctl[3];
		p.t1    = ~c.ctl[2];
		p.p2_5  = ~c.ctl[1];
		p.int_n = ~c.ctl[0];
		return p;
	endfunction

	// Advance n edges with inputs free 1 ns after each
	task automatic tick(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge I_CLK);
			#1;
		end
	endtask

	// One ALE pulse with the offset on the bus
	task automatic latch_address(input logic [`SND_DB_W-1:0] off, input port2_t p2);
		db_in      = off;
		port2      = p2;
		strobe.ale = 1'b1;
		tick(1);
		strobe.ale = 1'b0;
		tick(1);
		last_off   = off;
	endtask

	//==================================================
	// Compare tasks
	//==================================================
	task automatic cmp_byte(input logic [`SND_DB_W-1:0] got,
		input logic [`SND_DB_W-1:0] exp, input string what);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("[FAIL] %0t %s: got %02h expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic cmp_addr(input rom_addr_t got, input rom_addr_t exp, input string what);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("[FAIL] %0t %s: got %03h expected %03h", $time, what, got, exp);
		end
	endtask

	task automatic cmp_pins(input snd_pins_t got, input snd_pins_t exp, input string what);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("[FAIL] %0t %s: got %04b expected %04b", $time, what, got, exp);
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		$display("test %s done, %0d errors", name, err_cnt - errs_before);
	endtask

	//==================================================
	// Directed tests
	//==================================================
	task automatic test_reset();
		int e0;
		int n;
		e0 = err_cnt;
		n  = 0;
		rst_n = 1'b0;
		tick(8);
		cmp_byte(db_out, 8'h00, "db_out in reset");
		cmp_byte(dac, 8'h00, "dac in reset");
		cmp_pins(pins, 4'hf, "pins in reset");
		cmp_byte({7'b0, cpu_rst_n}, 8'h00, "core reset held");
		rst_n = 1'b1;
		// Core should come out one edge after the board
		while (cpu_rst_n !== 1'b1 && n < 16) begin
			tick(1);
			n++;
		end
		if (cpu_rst_n !== 1'b1) begin
			$display("Timeout: core reset was never released after board reset");
			timed_out = 1'b1;
		end else begin
			cmp_byte(n[7:0], 8'd1, "edges to core release");
		end
		finish_test("reset", e0);
	endtask

	task automatic test_addr_latch();
		int          e0;
		logic [31:0] r;
		e0 = err_cnt;
		for (int k = 0; k < 8; k++) begin
			r = rand_bits(16);
			latch_address(r[7:0], r[15:8]);
			cmp_addr(rom_addr, expect_addr(r[7:0], r[15:8]), "latched address");
			// Bus moves on while ALE stays low
			db_in = ~r[7:0];
			tick(3);
			cmp_addr(rom_addr, expect_addr(r[7:0], r[15:8]), "address held");
		end
		finish_test("addr_latch", e0);
	endtask

	task automatic test_prog_fetch();
		int                   e0;
		logic [31:0]          r;
		logic [`SND_DB_W-1:0] prev_off;
		e0 = err_cnt;
		strobe.psen_n = 1'b1;
		strobe.psen_n = 1'b0;
		for (int k = 0; k < 8; k++) begin
			r        = rand_bits(16);
			prev_off = last_off;
			latch_address(r[7:0], r[15:8]);
			// Return register still holds the fetch from the old offset
			cmp_byte(db_out, rom_model(expect_addr(prev_off, r[15:8])), "fetch before return");
			tick(1);
			cmp_byte(db_out, rom_model(expect_addr(r[7:0], r[15:8])), "program fetch");
		end
		strobe.psen_n = 1'b1;
		tick(2);
		cmp_byte(db_out, 8'h00, "idle bus");
		finish_test("prog_fetch", e0);
	endtask

	task automatic test_reads();
		int          e0;
		logic [31:0] r;
		port2_t      p2;
		e0 = err_cnt;
		for (int k = 0; k < 6; k++) begin
			r          = rand_bits(16);
			p2         = r[15:8];
			p2.sel_cmd = 1'b0;
			latch_address(r[7:0], p2);
			strobe.rd_n = 1'b0;
			tick(1);
			cmp_byte(db_out, rom_model(expect_addr(r[7:0], p2)), "data rom read");
			// Command latch read through the synchronizer
			r             = rand_bits(8);
			cmd           = r[7:0];
			port2.sel_cmd = 1'b1;
			strobe.rd_n   = 1'b0;
			tick(`SND_SYNC_STAGES + 2);
			cmp_byte(db_out, {4'h0, ~cmd.dat}, "command read");
			strobe.rd_n = 1'b1;
			tick(2);
		end
		finish_test("reads", e0);
	endtask

	task automatic test_pins();
		int          e0;
		logic [31:0] r;
		snd_pins_t   prev;
		snd_pins_t   exp;
		e0 = err_cnt;
		for (int k = 0; k < 8; k++) begin
			prev = pins_of(cmd);
			r    = rand_bits(8);
			cmd  = r[7:0];
			exp  = pins_of(cmd);
			tick(`SND_SYNC_STAGES - 1);
			cmp_pins(pins, prev, "pins before sync");
			tick(1);
			cmp_pins(pins, exp, "pins after sync");
			cmp_byte(port2_out, {2'b00, exp.p2_5, 5'b00000}, "port2_out");
		end
		finish_test("pins", e0);
	endtask

	task automatic test_dac();
		int                   e0;
		logic [31:0]          r;
		logic [`SND_DB_W-1:0] prev;
		e0 = err_cnt;
		for (int k = 0; k < 8; k++) begin
			prev  = port1;
			r     = rand_bits(8);
			port1 = r[7:0];
			// Sample must not move before the next edge
			#1;
			cmp_byte(dac, prev, "dac before edge");
			tick(1);
			cmp_byte(dac, r[7:0], "dac sample");
		end
		finish_test("dac", e0);
	endtask

	//==================================================
	// Main sequence
	//==================================================
	initial begin
		lfsr          = 32'he2ca_1a91;
		err_cnt       = 0;
		chk_cnt       = 0;
		timed_out     = 1'b0;
		last_off      = '0;
		rst_n         = 1'b0;
		db_in         = '0;
		port1         = '0;
		port2         = '0;
		cmd           = '0;
		strobe.ale    = 1'b0;
		strobe.rd_n   = 1'b1;
		strobe.psen_n = 1'b1;
		test_reset();
		if (!timed_out) begin
			test_addr_latch();
			test_prog_fetch();
			test_reads();
			test_pins();
			test_dac();
		end
		$display("checks %0d, errors %0d, timeouts %0d", chk_cnt, err_cnt, timed_out);
		if (err_cnt == 0 && !timed_out) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule
